// File: hdl/hero_axi_consts.svh
`ifndef HERO_AXI_CONSTS_SVH
`define HERO_AXI_CONSTS_SVH

// ID widths on either side of the bridge
`define HERO_ID_IN_W    17
`define HERO_ID_OUT_W   2

// One table entry per narrow ID
`define HERO_N_ENTRIES  (1 << `HERO_ID_OUT_W)

`define HERO_MAX_TXNS   4  // Outstanding bursts per entry
`define HERO_CNT_W      3  // Must hold HERO_MAX_TXNS itself

`define HERO_ADDR_IN_W  40
`define HERO_ADDR_OUT_W 49

`define HERO_DATA_W     128
`define HERO_STRB_W     (`HERO_DATA_W / 8)

`define HERO_LEN_W      8

`endif

// File: hdl/hero_axi_pkg.sv
`default_nettype none

`include "hero_axi_consts.svh"

package hero_axi_pkg;

  // Wide ID seen by the upstream master
  typedef logic [`HERO_ID_IN_W-1:0]    id_in_t;

  // Narrow ID, doubles as a remap table index
  typedef logic [`HERO_ID_OUT_W-1:0]   id_out_t;

  typedef logic [`HERO_ADDR_IN_W-1:0]  addr_in_t;
  typedef logic [`HERO_ADDR_OUT_W-1:0] addr_out_t;

  typedef logic [`HERO_DATA_W-1:0]     data_t;
  typedef logic [`HERO_STRB_W-1:0]     strb_t;

  typedef logic [`HERO_LEN_W-1:0]      len_t;

  typedef logic [1:0]                  resp_t;

  typedef logic [`HERO_CNT_W-1:0]      cnt_t;  // Live bursts per entry

endpackage

`default_nettype wire

// File: hdl/id_remap_if.sv
`timescale 1ns/10ps
`default_nettype none

interface id_remap_if;

  // Request side, one new transaction looking for a narrow ID
  logic                  req_valid;
  hero_axi_pkg::id_in_t  req_id;
  logic                  req_take;
  logic                  req_grant;
  hero_axi_pkg::id_out_t req_idx;

  // Release side, a response that finishes a transaction
  logic                  rel_valid;
  hero_axi_pkg::id_out_t rel_idx;
  hero_axi_pkg::id_in_t  rel_id;

  modport chan (
    output req_valid, req_id, req_take, rel_valid, rel_idx,
    input  req_grant, req_idx, rel_id
  );

  modport tbl (
    input  req_valid, req_id, req_take, rel_valid, rel_idx,
    output req_grant, req_idx, rel_id
  );

endinterface

`default_nettype wire

// File: hdl/id_remap_table.sv
`timescale 1ns/10ps
`default_nettype none

`include "hero_axi_consts.svh"

module id_remap_table #(
  parameter int N_ENTRIES = `HERO_N_ENTRIES
) (
  input  logic           clk_i,
  input  logic           arst_n_i,
  id_remap_if.tbl        rmp
);

  hero_axi_pkg::id_in_t  ids_q [N_ENTRIES];
  hero_axi_pkg::cnt_t    cnt_q [N_ENTRIES];

  logic                  hit;
  hero_axi_pkg::id_out_t hit_idx;
  logic                  free_found;
  hero_axi_pkg::id_out_t free_idx;
  logic                  room;

  logic [N_ENTRIES-1:0]  take_sel;
  logic [N_ENTRIES-1:0]  rel_sel;

  // Scan downwards so the lowest matching or free entry wins
  always_comb begin
    hit        = 1'b0;
    hit_idx    = '0;
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = N_ENTRIES - 1; i >= 0; i--) begin
      if (cnt_q[i] != '0 && ids_q[i] == rmp.req_id) begin
        hit     = 1'b1;
        hit_idx = hero_axi_pkg::id_out_t'(i);
      end
      if (cnt_q[i] == '0) begin
        free_found = 1'b1;
        free_idx   = hero_axi_pkg::id_out_t'(i);
      end
    end
  end

  // A live ID must stay on its entry, even when that entry is saturated
  assign room = hit ? (cnt_q[hit_idx] < `HERO_MAX_TXNS) : free_found;

  assign rmp.req_grant = rmp.req_valid && room;
  assign rmp.req_idx   = hit ? hit_idx : free_idx;
  assign rmp.rel_id    = ids_q[rmp.rel_idx];

  always_comb begin
    for (int i = 0; i < N_ENTRIES; i++) begin
      take_sel[i] = rmp.req_take  && (rmp.req_idx == i);
      rel_sel[i]  = rmp.rel_valid && (rmp.rel_idx == i);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < N_ENTRIES; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < N_ENTRIES; i++) begin
        if (take_sel[i] && !rel_sel[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end else if (rel_sel[i] && !take_sel[i]) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
    end
  end

  // Rewriting the same ID on a hit is harmless
  always_ff @(posedge clk_i) begin
    if (rmp.req_take) begin
      ids_q[rmp.req_idx] <= rmp.req_id;
    end
  end

endmodule

`default_nettype wire

// File: hdl/axi_id_remap_rd.sv
`timescale 1ns/10ps
`default_nettype none

module axi_id_remap_rd (
  input  hero_axi_pkg::id_in_t    ar_id_i,
  input  hero_axi_pkg::addr_in_t  ar_addr_i,
  input  hero_axi_pkg::len_t      ar_len_i,
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  output hero_axi_pkg::id_in_t    r_id_o,
  output hero_axi_pkg::data_t     r_data_o,
  output hero_axi_pkg::resp_t     r_resp_o,
  output logic                    r_last_o,
  output logic                    r_valid_o,
  input  logic                    r_ready_i,
  output hero_axi_pkg::id_out_t   m_ar_id_o,
  output hero_axi_pkg::addr_out_t m_ar_addr_o,
  output hero_axi_pkg::len_t      m_ar_len_o,
  output logic                    m_ar_valid_o,
  input  logic                    m_ar_ready_i,
  input  hero_axi_pkg::id_out_t   m_r_id_i,
  input  hero_axi_pkg::data_t     m_r_data_i,
  input  hero_axi_pkg::resp_t     m_r_resp_i,
  input  logic                    m_r_last_i,
  input  logic                    m_r_valid_i,
  output logic                    m_r_ready_o,
  id_remap_if.chan                rmp
);

  // AR only moves once the table has an entry for it
  assign m_ar_valid_o  = ar_valid_i && rmp.req_grant;
  assign ar_ready_o    = m_ar_ready_i && rmp.req_grant;
  assign m_ar_id_o     = rmp.req_idx;
  assign m_ar_addr_o   = hero_axi_pkg::addr_out_t'(ar_addr_i);  // Zero extension
  assign m_ar_len_o    = ar_len_i;

  assign rmp.req_valid = ar_valid_i;
  assign rmp.req_id    = ar_id_i;
  assign rmp.req_take  = ar_valid_i && ar_ready_o;

  assign r_id_o        = rmp.rel_id;
  assign r_data_o      = m_r_data_i;
  assign r_resp_o      = m_r_resp_i;
  assign r_last_o      = m_r_last_i;
  assign r_valid_o     = m_r_valid_i;
  assign m_r_ready_o   = r_ready_i;

  // A burst frees its slot only on the final beat
  assign rmp.rel_idx   = m_r_id_i;
  assign rmp.rel_valid = m_r_valid_i && r_ready_i && m_r_last_i;

endmodule

`default_nettype wire

// File: hdl/axi_id_remap_wr.sv
`timescale 1ns/10ps
`default_nettype none

module axi_id_remap_wr (
  input  hero_axi_pkg::id_in_t    aw_id_i,
  input  hero_axi_pkg::addr_in_t  aw_addr_i,
  input  hero_axi_pkg::len_t      aw_len_i,
  input  logic                    aw_valid_i,
  output logic                    aw_ready_o,
  input  hero_axi_pkg::data_t     w_data_i,
  input  hero_axi_pkg::strb_t     w_strb_i,
  input  logic                    w_last_i,
  input  logic                    w_valid_i,
  output logic                    w_ready_o,
  output hero_axi_pkg::id_in_t    b_id_o,
  output hero_axi_pkg::resp_t     b_resp_o,
  output logic                    b_valid_o,
  input  logic                    b_ready_i,
  output hero_axi_pkg::id_out_t   m_aw_id_o,
  output hero_axi_pkg::addr_out_t m_aw_addr_o,
  output hero_axi_pkg::len_t      m_aw_len_o,
  output logic                    m_aw_valid_o,
  input  logic                    m_aw_ready_i,
  output hero_axi_pkg::data_t     m_w_data_o,
  output hero_axi_pkg::strb_t     m_w_strb_o,
  output logic                    m_w_last_o,
  output logic                    m_w_valid_o,
  input  logic                    m_w_ready_i,
  input  hero_axi_pkg::id_out_t   m_b_id_i,
  input  hero_axi_pkg::resp_t     m_b_resp_i,
  input  logic                    m_b_valid_i,
  output logic                    m_b_ready_o,
  id_remap_if.chan                rmp
);

  assign m_aw_valid_o  = aw_valid_i && rmp.req_grant;
  assign aw_ready_o    = m_aw_ready_i && rmp.req_grant;
  assign m_aw_id_o     = rmp.req_idx;
  assign m_aw_addr_o   = hero_axi_pkg::addr_out_t'(aw_addr_i);
  assign m_aw_len_o    = aw_len_i;

  assign rmp.req_valid = aw_valid_i;
  assign rmp.req_id    = aw_id_i;
  assign rmp.req_take  = aw_valid_i && aw_ready_o;

  // W carries no ID in AXI4 so it needs no remapping
  assign m_w_data_o    = w_data_i;
  assign m_w_strb_o    = w_strb_i;
  assign m_w_last_o    = w_last_i;
  assign m_w_valid_o   = w_valid_i;
  assign w_ready_o     = m_w_ready_i;

  assign b_id_o        = rmp.rel_id;
  assign b_resp_o      = m_b_resp_i;
  assign b_valid_o     = m_b_valid_i;
  assign m_b_ready_o   = b_ready_i;

  assign rmp.rel_idx   = m_b_id_i;
  assign rmp.rel_valid = m_b_valid_i && b_ready_i;  // One B ends one burst

endmodule

`default_nettype wire

// File: hdl/axi_id_remap_top.sv
`timescale 1ns/10ps
`default_nettype none

module axi_id_remap_top (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  hero_axi_pkg::id_in_t    s_ar_id_i,
  input  hero_axi_pkg::addr_in_t  s_ar_addr_i,
  input  hero_axi_pkg::len_t      s_ar_len_i,
  input  logic                    s_ar_valid_i,
  output logic                    s_ar_ready_o,
  output hero_axi_pkg::id_in_t    s_r_id_o,
  output hero_axi_pkg::data_t     s_r_data_o,
  output hero_axi_pkg::resp_t     s_r_resp_o,
  output logic                    s_r_last_o,
  output logic                    s_r_valid_o,
  input  logic                    s_r_ready_i,
  input  hero_axi_pkg::id_in_t    s_aw_id_i,
  input  hero_axi_pkg::addr_in_t  s_aw_addr_i,
  input  hero_axi_pkg::len_t      s_aw_len_i,
  input  logic                    s_aw_valid_i,
  output logic                    s_aw_ready_o,
  input  hero_axi_pkg::data_t     s_w_data_i,
  input  hero_axi_pkg::strb_t     s_w_strb_i,
  input  logic                    s_w_last_i,
  input  logic                    s_w_valid_i,
  output logic                    s_w_ready_o,
  output hero_axi_pkg::id_in_t    s_b_id_o,
  output hero_axi_pkg::resp_t     s_b_resp_o,
  output logic                    s_b_valid_o,
  input  logic                    s_b_ready_i,
  output hero_axi_pkg::id_out_t   m_ar_id_o,
  output hero_axi_pkg::addr_out_t m_ar_addr_o,
  output hero_axi_pkg::len_t      m_ar_len_o,
  output logic                    m_ar_valid_o,
  input  logic                    m_ar_ready_i,
  input  hero_axi_pkg::id_out_t   m_r_id_i,
  input  hero_axi_pkg::data_t     m_r_data_i,
  input  hero_axi_pkg::resp_t     m_r_resp_i,
  input  logic                    m_r_last_i,
  input  logic                    m_r_valid_i,
  output logic                    m_r_ready_o,
  output hero_axi_pkg::id_out_t   m_aw_id_o,
  output hero_axi_pkg::addr_out_t m_aw_addr_o,
  output hero_axi_pkg::len_t      m_aw_len_o,
  output logic                    m_aw_valid_o,
  input  logic                    m_aw_ready_i,
  output hero_axi_pkg::data_t     m_w_data_o,
  output hero_axi_pkg::strb_t     m_w_strb_o,
  output logic                    m_w_last_o,
  output logic                    m_w_valid_o,
  input  logic                    m_w_ready_i,
  input  hero_axi_pkg::id_out_t   m_b_id_i,
  input  hero_axi_pkg::resp_t     m_b_resp_i,
  input  logic                    m_b_valid_i,
  output logic                    m_b_ready_o
);

  // Reads and writes keep separate tables since AR/R and AW/B are unordered
  id_remap_if rd_rmp ();
  id_remap_if wr_rmp ();

  id_remap_table i_rd_table (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .rmp      (rd_rmp)
  );

  id_remap_table i_wr_table (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .rmp      (wr_rmp)
  );

  axi_id_remap_rd i_rd (
    .ar_id_i      (s_ar_id_i),
    .ar_addr_i    (s_ar_addr_i),
    .ar_len_i     (s_ar_len_i),
    .ar_valid_i   (s_ar_valid_i),
    .ar_ready_o   (s_ar_ready_o),
    .r_id_o       (s_r_id_o),
    .r_data_o     (s_r_data_o),
    .r_resp_o     (s_r_resp_o),
    .r_last_o     (s_r_last_o),
    .r_valid_o    (s_r_valid_o),
    .r_ready_i    (s_r_ready_i),
    .m_ar_id_o    (m_ar_id_o),
    .m_ar_addr_o  (m_ar_addr_o),
    .m_ar_len_o   (m_ar_len_o),
    .m_ar_valid_o (m_ar_valid_o),
    .m_ar_ready_i (m_ar_ready_i),
    .m_r_id_i     (m_r_id_i),
    .m_r_data_i   (m_r_data_i),
    .m_r_resp_i   (m_r_resp_i),
    .m_r_last_i   (m_r_last_i),
    .m_r_valid_i  (m_r_valid_i),
    .m_r_ready_o  (m_r_ready_o),
    .rmp          (rd_rmp)
  );

  axi_id_remap_wr i_wr (
    .aw_id_i      (s_aw_id_i),
    .aw_addr_i    (s_aw_addr_i),
    .aw_len_i     (s_aw_len_i),
    .aw_valid_i   (s_aw_valid_i),
    .aw_ready_o   (s_aw_ready_o),
    .w_data_i     (s_w_data_i),
    .w_strb_i     (s_w_strb_i),
    .w_last_i     (s_w_last_i),
    .w_valid_i    (s_w_valid_i),
    .w_ready_o    (s_w_ready_o),
    .b_id_o       (s_b_id_o),
    .b_resp_o     (s_b_resp_o),
    .b_valid_o    (s_b_valid_o),
    .b_ready_i    (s_b_ready_i),
    .m_aw_id_o    (m_aw_id_o),
    .m_aw_addr_o  (m_aw_addr_o),
    .m_aw_len_o   (m_aw_len_o),
    .m_aw_valid_o (m_aw_valid_o),
    .m_aw_ready_i (m_aw_ready_i),
    .m_w_data_o   (m_w_data_o),
    .m_w_strb_o   (m_w_strb_o),
    .m_w_last_o   (m_w_last_o),
    .m_w_valid_o  (m_w_valid_o),
    .m_w_ready_i  (m_w_ready_i),
    .m_b_id_i     (m_b_id_i),
    .m_b_resp_i   (m_b_resp_i),
    .m_b_valid_i  (m_b_valid_i),
    .m_b_ready_o  (m_b_ready_o),
    .rmp          (wr_rmp)
  );

endmodule

`default_nettype wire

// File: verif/axi_id_remap_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module axi_id_remap_asserts (
  input logic                  clk_i,
  input logic                  arst_n_i,
  input logic                  s_ar_valid_i, s_ar_ready_i, m_ar_valid_i, m_ar_ready_i,
  input logic                  s_aw_valid_i, s_aw_ready_i, m_aw_valid_i, m_aw_ready_i,
  input logic                  s_w_valid_i, m_w_valid_i, m_r_valid_i, m_b_valid_i,
  input hero_axi_pkg::id_out_t m_ar_id_i, m_aw_id_i, m_r_id_i, m_b_id_i
);

  // Requests never appear downstream without an upstream source
  ar_valid_src: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_ar_valid_i |-> s_ar_valid_i) else $error("master AR valid without slave AR valid");
  aw_valid_src: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_aw_valid_i |-> s_aw_valid_i) else $error("master AW valid without slave AW valid");
  w_valid_src: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_w_valid_i |-> s_w_valid_i) else $error("master W valid without slave W valid");

  ar_hs_match: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (m_ar_valid_i && m_ar_ready_i) == (s_ar_valid_i && s_ar_ready_i))
    else $error("AR handshakes differ between slave and master side");
  aw_hs_match: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (m_aw_valid_i && m_aw_ready_i) == (s_aw_valid_i && s_aw_ready_i))
    else $error("AW handshakes differ between slave and master side");

  ar_id_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_ar_valid_i |-> !$isunknown(m_ar_id_i)) else $error("unknown master AR ID");
  aw_id_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_aw_valid_i |-> !$isunknown(m_aw_id_i)) else $error("unknown master AW ID");
  r_id_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_r_valid_i |-> !$isunknown(m_r_id_i)) else $error("unknown master R ID");
  b_id_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_b_valid_i |-> !$isunknown(m_b_id_i)) else $error("unknown master B ID");

endmodule

bind axi_id_remap_top axi_id_remap_asserts i_asserts (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .s_ar_valid_i (s_ar_valid_i),
  .s_ar_ready_i (s_ar_ready_o),
  .m_ar_valid_i (m_ar_valid_o),
  .m_ar_ready_i (m_ar_ready_i),
  .s_aw_valid_i (s_aw_valid_i),
  .s_aw_ready_i (s_aw_ready_o),
  .m_aw_valid_i (m_aw_valid_o),
  .m_aw_ready_i (m_aw_ready_i),
  .s_w_valid_i  (s_w_valid_i),
  .m_w_valid_i  (m_w_valid_o),
  .m_r_valid_i  (m_r_valid_i),
  .m_b_valid_i  (m_b_valid_i),
  .m_ar_id_i    (m_ar_id_o),
  .m_aw_id_i    (m_aw_id_o),
  .m_r_id_i     (m_r_id_i),
  .m_b_id_i     (m_b_id_i)
);

`default_nettype wire

// File: verif/tb_axi_id_remap.sv
`timescale 1ns/10ps
`default_nettype none

`include "hero_axi_consts.svh"

module tb_axi_id_remap;

  localparam int CLK_PERIOD = 8;
  localparam int HS_LIMIT   = 40;  // Cycles a request may wait for ready
  localparam int RAND_OPS   = 60;
  // Roughly 60 directed handshakes plus one per random op and up to 32 drain returns
  localparam int WATCHDOG_NS = ((60 + RAND_OPS + 32) * (HS_LIMIT + 4) + 50) * CLK_PERIOD;

  logic clk_i;
  logic arst_n_i;
  hero_axi_pkg::id_in_t    s_ar_id_i, s_r_id_o, s_aw_id_i, s_b_id_o;
  hero_axi_pkg::id_out_t   m_ar_id_o, m_r_id_i, m_aw_id_o, m_b_id_i;
  hero_axi_pkg::addr_in_t  s_ar_addr_i, s_aw_addr_i;
  hero_axi_pkg::addr_out_t m_ar_addr_o, m_aw_addr_o;
  hero_axi_pkg::len_t      s_ar_len_i, s_aw_len_i, m_ar_len_o, m_aw_len_o;
  hero_axi_pkg::data_t     s_r_data_o, s_w_data_i, m_r_data_i, m_w_data_o;
  hero_axi_pkg::strb_t     s_w_strb_i, m_w_strb_o;
  hero_axi_pkg::resp_t     s_r_resp_o, s_b_resp_o, m_r_resp_i, m_b_resp_i;
  logic s_ar_valid_i, s_ar_ready_o, m_ar_valid_o, m_ar_ready_i;
  logic s_r_last_o, s_r_valid_o, s_r_ready_i, m_r_last_i, m_r_valid_i, m_r_ready_o;
  logic s_aw_valid_i, s_aw_ready_o, m_aw_valid_o, m_aw_ready_i;
  logic s_w_last_i, s_w_valid_i, s_w_ready_o, m_w_last_o, m_w_valid_o, m_w_ready_i;
  logic s_b_valid_o, s_b_ready_i, m_b_valid_i, m_b_ready_o;

  // Allocation model where index 0 is the read table and 1 the write table
  hero_axi_pkg::id_in_t mdl_id  [2][`HERO_N_ENTRIES];
  int                   mdl_cnt [2][`HERO_N_ENTRIES];

  hero_axi_pkg::id_in_t id_pool [3] = '{17'h00011, 17'h1F00F, 17'h0A5A5};
  logic [31:0]          rng_state;
  int                   checks;
  int                   errors;
  int                   timeouts;

  axi_id_remap_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_val(input string name, input string what,
                           input logic [127:0] exp, input logic [127:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("CHECK FAILED %s: %s expected %0h, actual %0h", name, what, exp, act);
    end
  endtask

  // Lowest live entry with the same ID wins, then the lowest free one
  function automatic int predict_idx(input int dir, input hero_axi_pkg::id_in_t id);
    for (int i = 0; i < `HERO_N_ENTRIES; i++) begin
      if (mdl_cnt[dir][i] != 0 && mdl_id[dir][i] == id) begin
        return (mdl_cnt[dir][i] < `HERO_MAX_TXNS) ? i : -1;
      end
    end
    for (int i = 0; i < `HERO_N_ENTRIES; i++) begin
      if (mdl_cnt[dir][i] == 0) return i;
    end
    return -1;
  endfunction

  function automatic int live_entry(input int dir, input int start);
    int i;
    for (int k = 0; k < `HERO_N_ENTRIES; k++) begin
      i = (start + k) % `HERO_N_ENTRIES;
      if (mdl_cnt[dir][i] != 0) return i;
    end
    return -1;
  endfunction

  // All tasks are entered on a falling edge and return on one with their valids low
  task automatic issue_ar(input string name, input hero_axi_pkg::id_in_t id,
                          input hero_axi_pkg::addr_in_t addr, input hero_axi_pkg::len_t len,
                          input int exp_idx);
    int waited;
    waited = 0;
    s_ar_id_i = id;
    s_ar_addr_i = addr;
    s_ar_len_i = len;
    s_ar_valid_i = 1'b1;
    #1;
    while (!s_ar_ready_o && waited < HS_LIMIT) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (!s_ar_ready_o) begin
      timeouts++;
      $display("%s: read request with ID %0h was never accepted", name, id);
    end else begin
      check_val(name, "master ar valid", 1, m_ar_valid_o);
      check_val(name, "master ar id", exp_idx, m_ar_id_o);
      check_val(name, "master ar addr", {9'b0, addr}, m_ar_addr_o);
      check_val(name, "master ar len", len, m_ar_len_o);
      mdl_id[0][exp_idx] = id;
      mdl_cnt[0][exp_idx]++;
    end
    @(negedge clk_i);
    s_ar_valid_i = 1'b0;
  endtask

  task automatic issue_aw(input string name, input hero_axi_pkg::id_in_t id,
                          input hero_axi_pkg::addr_in_t addr, input hero_axi_pkg::len_t len,
                          input int exp_idx);
    int waited;
    waited = 0;
    s_aw_id_i = id;
    s_aw_addr_i = addr;
    s_aw_len_i = len;
    s_aw_valid_i = 1'b1;
    #1;
    while (!s_aw_ready_o && waited < HS_LIMIT) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (!s_aw_ready_o) begin
      timeouts++;
      $display("%s: write request with ID %0h was never accepted", name, id);
    end else begin
      check_val(name, "master aw valid", 1, m_aw_valid_o);
      check_val(name, "master aw id", exp_idx, m_aw_id_o);
      check_val(name, "master aw addr", {9'b0, addr}, m_aw_addr_o);
      check_val(name, "master aw len", len, m_aw_len_o);
      mdl_id[1][exp_idx] = id;
      mdl_cnt[1][exp_idx]++;
    end
    @(negedge clk_i);
    s_aw_valid_i = 1'b0;
    for (int b = 0; b <= int'(len); b++) begin
      s_w_data_i = {next_rand(), next_rand(), next_rand(), next_rand()};
      s_w_strb_i = hero_axi_pkg::strb_t'(next_rand());
      s_w_last_i = (b == int'(len));
      s_w_valid_i = 1'b1;
      #1;
      check_val(name, "master w valid", 1, m_w_valid_o);
      check_val(name, "master w data", s_w_data_i, m_w_data_o);
      check_val(name, "master w strb", s_w_strb_i, m_w_strb_o);
      check_val(name, "master w last", s_w_last_i, m_w_last_o);
      check_val(name, "slave w ready", 1, s_w_ready_o);
      @(negedge clk_i);
    end
    s_w_valid_i = 1'b0;
  endtask

  task automatic return_r(input string name, input int idx, input int beats);
    hero_axi_pkg::data_t data;
    hero_axi_pkg::resp_t resp;
    for (int b = 0; b < beats; b++) begin
      data = {next_rand(), next_rand(), next_rand(), next_rand()};
      resp = hero_axi_pkg::resp_t'(next_rand());
      m_r_id_i = hero_axi_pkg::id_out_t'(idx);
      m_r_data_i = data;
      m_r_resp_i = resp;
      m_r_last_i = (b == beats - 1);
      m_r_valid_i = 1'b1;
      #1;
      check_val(name, "r valid", 1, s_r_valid_o);
      check_val(name, "r id", mdl_id[0][idx], s_r_id_o);
      check_val(name, "r data", data, s_r_data_o);
      check_val(name, "r resp", resp, s_r_resp_o);
      check_val(name, "r last", b == beats - 1, s_r_last_o);
      check_val(name, "master r ready", 1, m_r_ready_o);
      @(negedge clk_i);
    end
    m_r_valid_i = 1'b0;
    m_r_last_i = 1'b0;
    mdl_cnt[0][idx]--;
  endtask

  task automatic return_b(input string name, input int idx);
    hero_axi_pkg::resp_t resp;
    resp = hero_axi_pkg::resp_t'(next_rand());
    m_b_id_i = hero_axi_pkg::id_out_t'(idx);
    m_b_resp_i = resp;
    m_b_valid_i = 1'b1;
    #1;
    check_val(name, "b valid", 1, s_b_valid_o);
    check_val(name, "b id", mdl_id[1][idx], s_b_id_o);
    check_val(name, "b resp", resp, s_b_resp_o);
    check_val(name, "master b ready", 1, m_b_ready_o);
    @(negedge clk_i);
    m_b_valid_i = 1'b0;
    mdl_cnt[1][idx]--;
  endtask

  task automatic drain_all(input string name);
    for (int i = 0; i < `HERO_N_ENTRIES; i++) begin
      while (mdl_cnt[0][i] != 0) return_r(name, i, 1);
      while (mdl_cnt[1][i] != 0) return_b(name, i);
    end
  endtask

  // Leaves the request valid so the caller decides how it ends
  task automatic expect_ar_stall(input string name, input hero_axi_pkg::id_in_t id);
    s_ar_id_i = id;
    s_ar_valid_i = 1'b1;
    repeat (3) begin
      #1;
      check_val(name, "stalled ar ready", 0, s_ar_ready_o);
      check_val(name, "stalled master ar valid", 0, m_ar_valid_o);
      @(negedge clk_i);
    end
  endtask

  task automatic single_read();
    issue_ar("read_path", 17'h1ABCD, 40'hF0_1234_5678, 8'd3, 0);
    return_r("read_path", 0, 4);
  endtask

  task automatic single_write();
    issue_aw("write_path", 17'h0BEEF, 40'h12_3456_789A, 8'd1, 0);
    return_b("write_path", 0);
  endtask

  task automatic allocation_order();
    issue_ar("allocation", 17'h0000A, 40'h100, 8'd0, 0);
    issue_ar("allocation", 17'h0000B, 40'h200, 8'd0, 1);
    issue_ar("allocation", 17'h0000A, 40'h300, 8'd0, 0);
    return_r("allocation", 1, 2);
    issue_ar("allocation", 17'h0000C, 40'h400, 8'd0, 1);
    drain_all("allocation");
  endtask

  task automatic full_table_stall();
    hero_axi_pkg::id_in_t ids [4] = '{17'h10001, 17'h10002, 17'h10003, 17'h10004};
    for (int i = 0; i < 4; i++) begin
      issue_ar("full_table", ids[i], 40'h1000 * (i + 1), 8'd0, i);
    end
    expect_ar_stall("full_table", 17'h1FFFF);
    return_r("full_table", 2, 1);
    issue_ar("full_table", 17'h1FFFF, 40'h0, 8'd0, 2);
    repeat (`HERO_MAX_TXNS - 1) issue_ar("full_table", ids[0], 40'h10, 8'd0, 0);
    expect_ar_stall("full_table", ids[0]);
    s_ar_valid_i = 1'b0;
    drain_all("full_table");
  endtask

  task automatic hold_under_backpressure();
    m_ar_ready_i = 1'b0;
    m_w_ready_i = 1'b0;
    s_r_ready_i = 1'b0;
    s_b_ready_i = 1'b0;
    s_ar_id_i = 17'h0D00D;
    s_ar_addr_i = 40'h80;
    s_ar_len_i = 8'd0;
    s_ar_valid_i = 1'b1;
    repeat (3) begin
      #1;
      check_val("backpressure", "ar ready", 0, s_ar_ready_o);
      check_val("backpressure", "master ar valid", 1, m_ar_valid_o);
      check_val("backpressure", "master ar id", 0, m_ar_id_o);
      check_val("backpressure", "slave w ready", 0, s_w_ready_o);
      check_val("backpressure", "master r ready", 0, m_r_ready_o);
      check_val("backpressure", "master b ready", 0, m_b_ready_o);
      @(negedge clk_i);
    end
    s_ar_valid_i = 1'b0;
    m_ar_ready_i = 1'b1;
    m_w_ready_i = 1'b1;
    s_r_ready_i = 1'b1;
    s_b_ready_i = 1'b1;
    // The held request never allocated so a new ID still gets entry 0
    issue_ar("backpressure", 17'h0E00E, 40'h90, 8'd0, 0);
    issue_ar("backpressure", 17'h0D00D, 40'h80, 8'd0, 1);
    drain_all("backpressure");
  endtask

  task automatic random_traffic();
    logic [31:0]          r;
    hero_axi_pkg::id_in_t id;
    int                   dir;
    int                   idx;
    repeat (RAND_OPS) begin
      r = next_rand();
      dir = int'(r[0]);
      id = id_pool[r[5:4] % 3];
      idx = predict_idx(dir, id);
      if (r[2:1] != 2'b00 && idx >= 0) begin
        if (dir == 0) issue_ar("random", id, {r, r[7:0]}, 8'd1, idx);
        else issue_aw("random", id, {r, r[7:0]}, 8'd0, idx);
      end else begin
        idx = live_entry(dir, int'(r[7:6]));  // Out of order across entries
        if (idx >= 0 && dir == 0) return_r("random", idx, 2);
        else if (idx >= 0) return_b("random", idx);
      end
    end
    drain_all("random");
  endtask

  initial begin
    rng_state = 32'd51228;
    checks = 0;
    errors = 0;
    timeouts = 0;
    for (int i = 0; i < `HERO_N_ENTRIES; i++) begin
      mdl_cnt[0][i] = 0;
      mdl_cnt[1][i] = 0;
    end
    {s_ar_id_i, s_ar_addr_i, s_ar_len_i, s_ar_valid_i} = '0;
    {s_aw_id_i, s_aw_addr_i, s_aw_len_i, s_aw_valid_i} = '0;
    {s_w_data_i, s_w_strb_i, s_w_last_i, s_w_valid_i} = '0;
    {m_r_id_i, m_r_data_i, m_r_resp_i, m_r_last_i, m_r_valid_i} = '0;
    {m_b_id_i, m_b_resp_i, m_b_valid_i} = '0;
    s_r_ready_i = 1'b1;
    s_b_ready_i = 1'b1;
    m_ar_ready_i = 1'b1;
    m_aw_ready_i = 1'b1;
    m_w_ready_i = 1'b1;
    arst_n_i = 1'b0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    single_read();
    single_write();
    allocation_order();
    full_table_stall();
    hold_under_backpressure();
    random_traffic();
    $display("Checks: %0d, mismatches: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hdl
hdl/hero_axi_pkg.sv
hdl/id_remap_if.sv
hdl/id_remap_table.sv
hdl/axi_id_remap_rd.sv
hdl/axi_id_remap_wr.sv
hdl/axi_id_remap_top.sv
verif/axi_id_remap_asserts.sv
verif/tb_axi_id_remap.sv

// File: Makefile
TOOL       = verilator
TOP        = tb_axi_id_remap
RTL_TOP    = axi_id_remap_top
FILELIST   = tb.f
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then exit 1; fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
